// ==== hw/replay_settings.svh ====
// Widths, sizes and APB register map of the packet capture and replay engine
`ifndef REPLAY_SETTINGS_SVH
`define REPLAY_SETTINGS_SVH

// Stream side
`define REPLAY_DATA_W      64
`define REPLAY_USER_W      8
`define REPLAY_QID_POS     0
`define REPLAY_NUM_QUEUES  2
`define REPLAY_QID_W       1

// Packet memory and replay
`define REPLAY_MEM_AW      8
`define REPLAY_COUNT_W     16
`define REPLAY_OUT_DEPTH   4

// APB register map, one block per queue
`define APB_AW             8
`define REG_Q_STRIDE       8'h10
`define REG_ADDR_LOW       8'h00
`define REG_ADDR_HIGH      8'h04
`define REG_REPLAY_CNT     8'h08
`define REG_STATUS         8'h0C
`define REG_CMD            8'h40

`endif

// ==== hw/replay_pkg.sv ====
// Shared types of the packet capture and replay engine
`default_nettype none

`include "replay_settings.svh"

package replay_pkg;

  // Opcode in bits 2:0 of the command register
  typedef enum logic [2:0] {
    CMD_NONE    = 3'd0,
    CMD_CLEAR   = 3'd1,
    CMD_ENABLE  = 3'd2,
    CMD_DISABLE = 3'd3,
    CMD_START   = 3'd4,
    CMD_STOP    = 3'd5
  } replay_cmd_e;

  typedef enum logic {
    RD_IDLE = 1'b0,
    RD_RUN  = 1'b1
  } reader_state_e;

  typedef logic [`REPLAY_MEM_AW-1:0]  addr_t;
  typedef logic [`REPLAY_COUNT_W-1:0] count_t;
  typedef logic [`REPLAY_QID_W-1:0]   qid_t;

endpackage

`default_nettype wire

// ==== hw/replay_regs.sv ====
// APB register block with per-queue limits, replay count, commands and status
`timescale 1ns/1ps
`default_nettype none

`include "replay_settings.svh"

module replay_regs (
  input  wire logic                                         axi_aclk,
  input  wire logic                                         arst_n,
  input  wire logic                                         psel,
  input  wire logic                                         penable,
  input  wire logic                                         pwrite,
  input  wire logic [`APB_AW-1:0]                           paddr,
  input  wire logic [31:0]                                  pwdata,
  output logic [31:0]                                       prdata,
  output logic                                              pready,
  output logic                                              pslverr,
  input  wire replay_pkg::addr_t [`REPLAY_NUM_QUEUES-1:0]   capture_end,
  input  wire logic [`REPLAY_NUM_QUEUES-1:0]                busy,
  output replay_pkg::addr_t [`REPLAY_NUM_QUEUES-1:0]        addr_low,
  output replay_pkg::addr_t [`REPLAY_NUM_QUEUES-1:0]        addr_high,
  output replay_pkg::count_t [`REPLAY_NUM_QUEUES-1:0]       replay_count,
  output logic [`REPLAY_NUM_QUEUES-1:0]                     q_enable,
  output logic [`REPLAY_NUM_QUEUES-1:0]                     clear_pulse,
  output logic [`REPLAY_NUM_QUEUES-1:0]                     start_pulse,
  output logic [`REPLAY_NUM_QUEUES-1:0]                     stop_pulse
);

  logic [`APB_AW-1:0]      blk;
  logic [`APB_AW-1:0]      offset;
  replay_pkg::qid_t        q_sel;
  logic                    is_qblk;
  logic                    is_cmd;
  logic                    wr_ok;
  replay_pkg::replay_cmd_e cmd_op;
  replay_pkg::qid_t        cmd_q;

  assign blk    = paddr / `REG_Q_STRIDE;
  assign offset = paddr % `REG_Q_STRIDE;
  assign q_sel  = replay_pkg::qid_t'(blk);

  assign is_qblk = (blk < `REPLAY_NUM_QUEUES) &&
                   (offset == `REG_ADDR_LOW || offset == `REG_ADDR_HIGH ||
                    offset == `REG_REPLAY_CNT || offset == `REG_STATUS);
  assign is_cmd  = (paddr == `REG_CMD);

  // No wait states
  assign pready  = 1'b1;
  assign pslverr = psel & penable & ~(is_qblk | is_cmd);
  assign wr_ok   = psel & penable & pwrite & (is_qblk | is_cmd);

  // Command word: queue ID from bit 8, opcode in bits 2:0
  assign cmd_op = replay_pkg::replay_cmd_e'(pwdata[2:0]);
  assign cmd_q  = pwdata[8 +: `REPLAY_QID_W];

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      addr_low     <= '0;
      addr_high    <= '0;
      replay_count <= '0;
    end else if (wr_ok && is_qblk) begin
      case (offset)
        `REG_ADDR_LOW:   addr_low[q_sel]     <= pwdata[`REPLAY_MEM_AW-1:0];
        `REG_ADDR_HIGH:  addr_high[q_sel]    <= pwdata[`REPLAY_MEM_AW-1:0];
        `REG_REPLAY_CNT: replay_count[q_sel] <= pwdata[`REPLAY_COUNT_W-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      q_enable    <= '0;
      clear_pulse <= '0;
      start_pulse <= '0;
      stop_pulse  <= '0;
    end else begin
      clear_pulse <= '0;
      start_pulse <= '0;
      stop_pulse  <= '0;
      if (wr_ok && is_cmd) begin
        case (cmd_op)
          replay_pkg::CMD_CLEAR:   clear_pulse[cmd_q] <= 1'b1;
          replay_pkg::CMD_ENABLE:  q_enable[cmd_q]    <= 1'b1;
          replay_pkg::CMD_DISABLE: q_enable[cmd_q]    <= 1'b0;
          replay_pkg::CMD_START:   start_pulse[cmd_q] <= 1'b1;
          replay_pkg::CMD_STOP:    stop_pulse[cmd_q]  <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    prdata = '0;
    if (is_qblk) begin
      case (offset)
        `REG_ADDR_LOW:   prdata[`REPLAY_MEM_AW-1:0]  = addr_low[q_sel];
        `REG_ADDR_HIGH:  prdata[`REPLAY_MEM_AW-1:0]  = addr_high[q_sel];
        `REG_REPLAY_CNT: prdata[`REPLAY_COUNT_W-1:0] = replay_count[q_sel];
        `REG_STATUS: begin
          prdata[0]                   = busy[q_sel];
          prdata[16 +: `REPLAY_MEM_AW] = capture_end[q_sel] - addr_low[q_sel];
        end
        default: ;
      endcase
    end
  end

  // Access phase always follows a setup phase and completes at once
  assert property (@(posedge axi_aclk) disable iff (!arst_n)
    psel && penable |-> pready && $past(psel && !penable))
    else $error("APB access phase without setup phase");

endmodule

`default_nettype wire

// ==== hw/capture_writer.sv ====
// Capture side, steers stream beats into the memory region of their queue
`timescale 1ns/1ps
`default_nettype none

`include "replay_settings.svh"

module capture_writer (
  input  wire logic                                         axi_aclk,
  input  wire logic                                         arst_n,
  input  wire logic [`REPLAY_DATA_W-1:0]                    s_axis_tdata,
  input  wire logic [`REPLAY_USER_W-1:0]                    s_axis_tuser,
  input  wire logic                                         s_axis_tvalid,
  output logic                                              s_axis_tready,
  input  wire logic                                         s_axis_tlast,
  input  wire replay_pkg::addr_t [`REPLAY_NUM_QUEUES-1:0]   addr_low,
  input  wire replay_pkg::addr_t [`REPLAY_NUM_QUEUES-1:0]   addr_high,
  input  wire logic [`REPLAY_NUM_QUEUES-1:0]                q_enable,
  input  wire logic [`REPLAY_NUM_QUEUES-1:0]                clear_pulse,
  output replay_pkg::addr_t [`REPLAY_NUM_QUEUES-1:0]        capture_end,
  output logic                                              wr_en,
  output replay_pkg::addr_t                                 wr_addr,
  output logic [`REPLAY_DATA_W:0]                           wr_data
);

  logic             beat;
  logic             in_pkt;
  replay_pkg::qid_t pkt_q;
  replay_pkg::qid_t beat_q;

  assign beat   = s_axis_tvalid & s_axis_tready;
  // Queue of the first beat holds for the whole packet
  assign beat_q = in_pkt ? pkt_q : s_axis_tuser[`REPLAY_QID_POS +: `REPLAY_QID_W];

  // Beats past the region end are accepted and dropped
  assign wr_addr = capture_end[beat_q];
  assign wr_en   = beat && q_enable[beat_q] && (wr_addr <= addr_high[beat_q]);
  assign wr_data = {s_axis_tlast, s_axis_tdata};

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      s_axis_tready <= 1'b0;
      in_pkt        <= 1'b0;
      pkt_q         <= '0;
    end else begin
      s_axis_tready <= 1'b1;
      if (beat) begin
        in_pkt <= ~s_axis_tlast;
        pkt_q  <= beat_q;
      end
    end
  end

  // Write pointers, loaded from addr_low by a clear command
  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      capture_end <= '0;
    end else begin
      for (int q = 0; q < `REPLAY_NUM_QUEUES; q++) begin
        if (clear_pulse[q]) begin
          capture_end[q] <= addr_low[q];
        end else if (wr_en && beat_q == replay_pkg::qid_t'(q)) begin
          capture_end[q] <= capture_end[q] + 1'b1;
        end
      end
    end
  end

  // Holds once limits were applied by a clear
  assert property (@(posedge axi_aclk) disable iff (!arst_n)
    wr_en |-> wr_addr >= addr_low[beat_q] && wr_addr <= addr_high[beat_q])
    else $error("capture write at %0h outside region of queue %0d", wr_addr, beat_q);

endmodule

`default_nettype wire

// ==== hw/packet_mem.sv ====
// Shared packet memory, one write port and one registered read port
`timescale 1ns/1ps
`default_nettype none

`include "replay_settings.svh"

module packet_mem (
  input  wire logic                  axi_aclk,
  input  wire logic                  wr_en,
  input  wire replay_pkg::addr_t     wr_addr,
  input  wire logic [`REPLAY_DATA_W:0] wr_data,
  input  wire logic                  rd_en,
  input  wire replay_pkg::addr_t     rd_addr,
  output logic [`REPLAY_DATA_W:0]    rd_data
);

  // Top bit of each word is the last flag
  logic [`REPLAY_DATA_W:0] mem [0:(1 << `REPLAY_MEM_AW)-1];

  always_ff @(posedge axi_aclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== hw/replay_reader.sv ====
// Replay scheduler with round-robin reads over busy queues and pass counting
`timescale 1ns/1ps
`default_nettype none

`include "replay_settings.svh"

module replay_reader (
  input  wire logic                                         axi_aclk,
  input  wire logic                                         arst_n,
  input  wire replay_pkg::addr_t [`REPLAY_NUM_QUEUES-1:0]   addr_low,
  input  wire replay_pkg::addr_t [`REPLAY_NUM_QUEUES-1:0]   capture_end,
  input  wire replay_pkg::count_t [`REPLAY_NUM_QUEUES-1:0]  replay_count,
  input  wire logic [`REPLAY_NUM_QUEUES-1:0]                start_pulse,
  input  wire logic [`REPLAY_NUM_QUEUES-1:0]                stop_pulse,
  input  wire logic [`REPLAY_NUM_QUEUES-1:0]                space,
  input  wire logic [`REPLAY_DATA_W:0]                      rd_data,
  output logic                                              rd_en,
  output replay_pkg::addr_t                                 rd_addr,
  output logic [`REPLAY_NUM_QUEUES-1:0]                     busy,
  output logic [`REPLAY_NUM_QUEUES-1:0]                     push,
  output logic [`REPLAY_DATA_W:0]                           push_data
);

  replay_pkg::reader_state_e state  [`REPLAY_NUM_QUEUES];
  replay_pkg::addr_t         rd_ptr [`REPLAY_NUM_QUEUES];
  replay_pkg::count_t        passes [`REPLAY_NUM_QUEUES];
  replay_pkg::qid_t          rr;
  replay_pkg::qid_t          grant_q;
  logic                      grant;
  logic                      tag_valid;
  replay_pkg::qid_t          tag_q;

  always_comb begin
    for (int q = 0; q < `REPLAY_NUM_QUEUES; q++) begin
      busy[q] = (state[q] == replay_pkg::RD_RUN);
    end
  end

  // First busy queue with space searching from rr
  always_comb begin
    int idx;
    grant   = 1'b0;
    grant_q = rr;
    for (int k = 0; k < `REPLAY_NUM_QUEUES; k++) begin
      idx = (int'(rr) + k) % `REPLAY_NUM_QUEUES;
      if (!grant && busy[idx] && space[idx]) begin
        grant   = 1'b1;
        grant_q = replay_pkg::qid_t'(idx);
      end
    end
  end

  assign rd_en   = grant;
  assign rd_addr = rd_ptr[grant_q];

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      rr        <= '0;
      tag_valid <= 1'b0;
      tag_q     <= '0;
      for (int q = 0; q < `REPLAY_NUM_QUEUES; q++) begin
        state[q]  <= replay_pkg::RD_IDLE;
        rd_ptr[q] <= '0;
        passes[q] <= '0;
      end
    end else begin
      tag_valid <= grant;
      tag_q     <= grant_q;
      if (grant) begin
        rr <= (int'(grant_q) == `REPLAY_NUM_QUEUES - 1) ? '0 : grant_q + 1'b1;
      end
      for (int q = 0; q < `REPLAY_NUM_QUEUES; q++) begin
        if (stop_pulse[q]) begin
          state[q] <= replay_pkg::RD_IDLE;
        end else if (state[q] == replay_pkg::RD_IDLE) begin
          // Empty region or zero count ignores the start
          if (start_pulse[q] && capture_end[q] != addr_low[q] && replay_count[q] != '0) begin
            state[q]  <= replay_pkg::RD_RUN;
            rd_ptr[q] <= addr_low[q];
            passes[q] <= replay_count[q];
          end
        end else if (grant && grant_q == replay_pkg::qid_t'(q)) begin
          if (rd_ptr[q] + 1'b1 != capture_end[q]) begin
            rd_ptr[q] <= rd_ptr[q] + 1'b1;
          end else if (passes[q] == 1) begin
            state[q] <= replay_pkg::RD_IDLE;
          end else begin
            passes[q] <= passes[q] - 1'b1;
            rd_ptr[q] <= addr_low[q];
          end
        end
      end
    end
  end

  // Read data returns one cycle later tagged with its queue
  always_comb begin
    push = '0;
    if (tag_valid) begin
      push[tag_q] = 1'b1;
    end
  end

  assign push_data = rd_data;

  // Reads stay inside the captured part of the granted queue's region
  assert property (@(posedge axi_aclk) disable iff (!arst_n)
    rd_en |-> rd_addr >= addr_low[grant_q] && rd_addr != capture_end[grant_q])
    else $error("read at %0h outside captured data of queue %0d", rd_addr, grant_q);

endmodule

`default_nettype wire

// ==== hw/replay_out.sv ====
// Per-queue output FIFO that drives an AXI-Stream master port
`timescale 1ns/1ps
`default_nettype none

`include "replay_settings.svh"

module replay_out #(
  parameter int DEPTH = `REPLAY_OUT_DEPTH
) (
  input  wire logic                      axi_aclk,
  input  wire logic                      arst_n,
  input  wire logic                      push,
  input  wire logic [`REPLAY_DATA_W:0]   push_data,
  output logic                           space,
  output logic [`REPLAY_DATA_W-1:0]      m_axis_tdata,
  output logic                           m_axis_tlast,
  output logic                           m_axis_tvalid,
  input  wire logic                      m_axis_tready
);

  localparam int PW = $clog2(DEPTH);

  logic [`REPLAY_DATA_W:0] mem [DEPTH];
  logic [PW-1:0]           wr_ptr;
  logic [PW-1:0]           rd_ptr;
  logic [PW:0]             count;
  logic                    pop;

  assign m_axis_tvalid = (count != '0);
  assign pop           = m_axis_tvalid & m_axis_tready;
  assign {m_axis_tlast, m_axis_tdata} = mem[rd_ptr];

  // One slot held back for a read still in flight
  assign space = (count + 1'b1) < DEPTH;

  always_ff @(posedge axi_aclk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + push - pop;
    end
  end

  assert property (@(posedge axi_aclk) disable iff (!arst_n)
    push |-> count < DEPTH)
    else $error("push into full output FIFO");

endmodule

`default_nettype wire

// ==== hw/pcap_replay_top.sv ====
// Packet capture and replay engine with APB control and per-queue stream outputs
`timescale 1ns/1ps
`default_nettype none

`include "replay_settings.svh"

module pcap_replay_top (
  input  wire logic                                             axi_aclk,
  input  wire logic                                             arst_n,
  input  wire logic                                             psel,
  input  wire logic                                             penable,
  input  wire logic                                             pwrite,
  input  wire logic [`APB_AW-1:0]                               paddr,
  input  wire logic [31:0]                                      pwdata,
  output wire logic [31:0]                                      prdata,
  output wire logic                                             pready,
  output wire logic                                             pslverr,
  input  wire logic [`REPLAY_DATA_W-1:0]                        s_axis_tdata,
  input  wire logic [`REPLAY_USER_W-1:0]                        s_axis_tuser,
  input  wire logic                                             s_axis_tvalid,
  output wire logic                                             s_axis_tready,
  input  wire logic                                             s_axis_tlast,
  output wire logic [`REPLAY_NUM_QUEUES-1:0][`REPLAY_DATA_W-1:0] m_axis_tdata,
  output wire logic [`REPLAY_NUM_QUEUES-1:0]                    m_axis_tvalid,
  input  wire logic [`REPLAY_NUM_QUEUES-1:0]                    m_axis_tready,
  output wire logic [`REPLAY_NUM_QUEUES-1:0]                    m_axis_tlast
);

  wire replay_pkg::addr_t [`REPLAY_NUM_QUEUES-1:0]  addr_low;
  wire replay_pkg::addr_t [`REPLAY_NUM_QUEUES-1:0]  addr_high;
  wire replay_pkg::addr_t [`REPLAY_NUM_QUEUES-1:0]  capture_end;
  wire replay_pkg::count_t [`REPLAY_NUM_QUEUES-1:0] replay_count;
  wire logic [`REPLAY_NUM_QUEUES-1:0]               q_enable;
  wire logic [`REPLAY_NUM_QUEUES-1:0]               clear_pulse;
  wire logic [`REPLAY_NUM_QUEUES-1:0]               start_pulse;
  wire logic [`REPLAY_NUM_QUEUES-1:0]               stop_pulse;
  wire logic [`REPLAY_NUM_QUEUES-1:0]               busy;
  wire logic [`REPLAY_NUM_QUEUES-1:0]               push;
  wire logic [`REPLAY_NUM_QUEUES-1:0]               space;
  wire logic [`REPLAY_DATA_W:0]                     push_data;
  wire logic                                        wr_en;
  wire replay_pkg::addr_t                           wr_addr;
  wire logic [`REPLAY_DATA_W:0]                     wr_data;
  wire logic                                        rd_en;
  wire replay_pkg::addr_t                           rd_addr;
  wire logic [`REPLAY_DATA_W:0]                     rd_data;

  replay_regs u_regs (
    .axi_aclk, .arst_n,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .capture_end, .busy,
    .addr_low, .addr_high, .replay_count,
    .q_enable, .clear_pulse, .start_pulse, .stop_pulse
  );

  capture_writer u_writer (
    .axi_aclk, .arst_n,
    .s_axis_tdata, .s_axis_tuser, .s_axis_tvalid, .s_axis_tready, .s_axis_tlast,
    .addr_low, .addr_high, .q_enable, .clear_pulse,
    .capture_end, .wr_en, .wr_addr, .wr_data
  );

  packet_mem u_mem (
    .axi_aclk, .wr_en, .wr_addr, .wr_data, .rd_en, .rd_addr, .rd_data
  );

  replay_reader u_reader (
    .axi_aclk, .arst_n,
    .addr_low, .capture_end, .replay_count, .start_pulse, .stop_pulse,
    .space, .rd_data, .rd_en, .rd_addr, .busy, .push, .push_data
  );

  for (genvar q = 0; q < `REPLAY_NUM_QUEUES; q++) begin : g_out
    replay_out #(.DEPTH(`REPLAY_OUT_DEPTH)) u_out (
      .axi_aclk      (axi_aclk),
      .arst_n        (arst_n),
      .push          (push[q]),
      .push_data     (push_data),
      .space         (space[q]),
      .m_axis_tdata  (m_axis_tdata[q]),
      .m_axis_tlast  (m_axis_tlast[q]),
      .m_axis_tvalid (m_axis_tvalid[q]),
      .m_axis_tready (m_axis_tready[q])
    );
  end

endmodule

`default_nettype wire

// ==== verif/replay_tb.sv ====
// Testbench for the packet capture and replay engine with APB and stream stimulus and checks
`timescale 1ns/1ps
`default_nettype none

`include "replay_settings.svh"

module replay_tb;

  localparam int NQ = `REPLAY_NUM_QUEUES;
  localparam int WW = `REPLAY_DATA_W + 1;
  // Room for a full 200 pass replay in region_stop plus the shorter tests
  localparam int CYCLE_LIMIT = 4000;

  logic                              axi_aclk = 1'b0;
  logic                              arst_n;
  logic                              psel;
  logic                              penable;
  logic                              pwrite;
  logic [`APB_AW-1:0]                paddr;
  logic [31:0]                       pwdata;
  logic [31:0]                       prdata;
  logic                              pready;
  logic                              pslverr;
  logic [`REPLAY_DATA_W-1:0]         s_axis_tdata;
  logic [`REPLAY_USER_W-1:0]         s_axis_tuser;
  logic                              s_axis_tvalid;
  logic                              s_axis_tready;
  logic                              s_axis_tlast;
  logic [NQ-1:0][`REPLAY_DATA_W-1:0] m_axis_tdata;
  logic [NQ-1:0]                     m_axis_tvalid;
  logic [NQ-1:0]                     m_axis_tready;
  logic [NQ-1:0]                     m_axis_tlast;

  // Reference model with stored words per queue and expected output beats
  logic [WW-1:0] cap_mem [NQ][64];
  int            cap_len [NQ] = '{default: 0};
  int            region_size [NQ] = '{default: 0};
  int            pass_cnt [NQ] = '{default: 0};
  logic          model_en [NQ] = '{default: 1'b0};
  logic [WW-1:0] exp0 [$];
  logic [WW-1:0] exp1 [$];
  logic [WW-1:0] exp_head [NQ] = '{default: '0};
  int            exp_left [NQ] = '{default: 0};
  int            beats_seen [NQ] = '{default: 0};
  logic          accepting [NQ] = '{default: 1'b0};
  logic [NQ-1:0] ready_pat [256];
  logic [7:0]    pat_idx = '0;
  logic          rand_ready = 1'b0;
  int            cycles = 0;
  string         test_name = "reset";

  pcap_replay_top DUT (
    .axi_aclk, .arst_n,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .s_axis_tdata, .s_axis_tuser, .s_axis_tvalid, .s_axis_tready, .s_axis_tlast,
    .m_axis_tdata, .m_axis_tvalid, .m_axis_tready, .m_axis_tlast
  );

  always #4 axi_aclk = ~axi_aclk;

  task automatic fail_with(input string line);
    $display("%s", line);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic expect_eq(input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp)
      else fail_with($sformatf("mismatch %s expected %0h actual %0h", test_name, exp, act));
  endtask

  function automatic logic [`APB_AW-1:0] reg_addr(input int q, input logic [`APB_AW-1:0] off);
    logic [`APB_AW-1:0] base;
    base = q[`APB_AW-1:0];
    return base * `REG_Q_STRIDE + off;
  endfunction

  task automatic apb_access(input logic write, input logic [`APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(negedge axi_aclk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge axi_aclk);
    penable = 1'b1;
    // Sample mid access phase away from both clock edges
    #1;
    rdata = prdata;
    err   = pslverr;
    @(negedge axi_aclk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_reg(input logic [`APB_AW-1:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, addr, data, rdata, err);
    expect_eq(64'd0, {63'd0, err});
  endtask

  task automatic read_check(input logic [`APB_AW-1:0] addr, input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b0, addr, '0, rdata, err);
    expect_eq(64'd0, {63'd0, err});
    expect_eq({32'd0, exp}, {32'd0, rdata});
  endtask

  task automatic set_region(input int q, input int low, input int high);
    write_reg(reg_addr(q, `REG_ADDR_LOW), low);
    write_reg(reg_addr(q, `REG_ADDR_HIGH), high);
    region_size[q] = high - low + 1;
  endtask

  task automatic set_count(input int q, input int count);
    write_reg(reg_addr(q, `REG_REPLAY_CNT), count);
    pass_cnt[q] = count;
  endtask

  task automatic issue_cmd(input int q, input replay_pkg::replay_cmd_e op);
    logic [31:0] word;
    word = '0;
    word[2:0] = op;
    word[8 +: `REPLAY_QID_W] = q[`REPLAY_QID_W-1:0];
    write_reg(`REG_CMD, word);
    case (op)
      replay_pkg::CMD_CLEAR:   cap_len[q] = 0;
      replay_pkg::CMD_ENABLE:  model_en[q] = 1'b1;
      replay_pkg::CMD_DISABLE: model_en[q] = 1'b0;
      default: ;
    endcase
  endtask

  // Status word has busy in bit 0 and the captured word count from bit 16
  task automatic check_status(input int q, input int busy, input int count);
    read_check(reg_addr(q, `REG_STATUS), (count << 16) | busy);
  endtask

  task automatic send_packet(input int q, input int len);
    logic [WW-1:0]              word;
    logic                       last_flag;
    logic [`REPLAY_USER_W-1:0]  user;
    for (int i = 0; i < len; i++) begin
      @(negedge axi_aclk);
      last_flag = (i == len - 1);
      word = {last_flag, $urandom, $urandom};
      user = '0;
      user[`REPLAY_QID_POS +: `REPLAY_QID_W] = q[`REPLAY_QID_W-1:0];
      s_axis_tvalid = 1'b1;
      s_axis_tdata  = word[`REPLAY_DATA_W-1:0];
      s_axis_tlast  = last_flag;
      s_axis_tuser  = user;
      while (!s_axis_tready) @(negedge axi_aclk);
      // Disabled queue or full region drops the beat
      if (model_en[q] && cap_len[q] < region_size[q]) begin
        cap_mem[q][cap_len[q]] = word;
        cap_len[q] = cap_len[q] + 1;
      end
    end
    @(negedge axi_aclk);
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
  endtask

  task automatic start_replay(input int q);
    @(posedge axi_aclk);
    for (int p = 0; p < pass_cnt[q]; p++) begin
      for (int i = 0; i < cap_len[q]; i++) begin
        if (q == 0) exp0.push_back(cap_mem[q][i]);
        else exp1.push_back(cap_mem[q][i]);
      end
    end
    issue_cmd(q, replay_pkg::CMD_START);
  endtask

  task automatic wait_drained();
    while (exp_left[0] != 0 || exp_left[1] != 0) @(posedge axi_aclk);
  endtask

  // Output side retires accepted beats, drives tready and publishes the next expected head
  always @(negedge axi_aclk) begin
    if (accepting[0] && exp0.size() != 0) void'(exp0.pop_front());
    if (accepting[1] && exp1.size() != 0) void'(exp1.pop_front());
    for (int q = 0; q < NQ; q++) begin
      if (accepting[q]) beats_seen[q] = beats_seen[q] + 1;
    end
    m_axis_tready = rand_ready ? ready_pat[pat_idx] : '1;
    pat_idx = pat_idx + 1'b1;
    for (int q = 0; q < NQ; q++) begin
      accepting[q] = arst_n && m_axis_tvalid[q] && m_axis_tready[q];
    end
    exp_left[0] = exp0.size();
    exp_left[1] = exp1.size();
    exp_head[0] = (exp0.size() != 0) ? exp0[0] : '0;
    exp_head[1] = (exp1.size() != 0) ? exp1[0] : '0;
  end

  for (genvar q = 0; q < NQ; q++) begin : g_out_chk
    assert property (@(posedge axi_aclk) disable iff (!arst_n)
      m_axis_tvalid[q] && m_axis_tready[q] |-> exp_left[q] != 0)
      else fail_with($sformatf("Output %0d sent a beat nobody expected in %s", q, test_name));
    assert property (@(posedge axi_aclk) disable iff (!arst_n)
      m_axis_tvalid[q] && m_axis_tready[q] |-> {m_axis_tlast[q], m_axis_tdata[q]} == exp_head[q])
      else fail_with($sformatf("mismatch %s output %0d expected %0h actual %0h", test_name, q,
                               exp_head[q], $sampled({m_axis_tlast[q], m_axis_tdata[q]})));
    assert property (@(posedge axi_aclk) disable iff (!arst_n)
      m_axis_tvalid[q] && !m_axis_tready[q] |=>
        m_axis_tvalid[q] && $stable({m_axis_tlast[q], m_axis_tdata[q]}))
      else fail_with($sformatf("Output %0d dropped or changed a stalled beat", q));
  end

  assert property (@(posedge axi_aclk) disable iff (!arst_n)
    psel && penable |-> pready)
    else fail_with($sformatf("APB access phase without pready in %s", test_name));

  always @(posedge axi_aclk) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      fail_with($sformatf("Run hung, cycle limit reached in %s", test_name));
    end
  end

  initial begin
    int unused_seed;
    int base;
    int stop_mark;
    unused_seed = $urandom(993);
    // About one stall cycle in four on each output
    for (int i = 0; i < 256; i++) begin
      ready_pat[i] = {($urandom % 4) != 0, ($urandom % 4) != 0};
    end
    arst_n        = 1'b0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    s_axis_tdata  = '0;
    s_axis_tuser  = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = '0;
    repeat (16) @(posedge axi_aclk);
    @(negedge axi_aclk);
    arst_n = 1'b1;

    test_name = "apb_regs";
    set_region(0, 'h00, 'h3F);
    set_region(1, 'h40, 'h7F);
    set_count(0, 'h1234);
    set_count(1, 'h0005);
    read_check(reg_addr(0, `REG_ADDR_LOW), 'h00);
    read_check(reg_addr(0, `REG_ADDR_HIGH), 'h3F);
    read_check(reg_addr(0, `REG_REPLAY_CNT), 'h1234);
    read_check(reg_addr(1, `REG_ADDR_LOW), 'h40);
    read_check(reg_addr(1, `REG_ADDR_HIGH), 'h7F);
    read_check(reg_addr(1, `REG_REPLAY_CNT), 'h0005);
    check_status(0, 0, 0);
    begin
      logic [31:0] rdata;
      logic        err;
      // Block 2 aliases the low limit of queue 0 if the block decode is partial
      apb_access(1'b1, 8'h20, 32'hFF, rdata, err);
      expect_eq(64'd1, {63'd0, err});
      apb_access(1'b0, 8'h44, '0, rdata, err);
      expect_eq(64'd1, {63'd0, err});
    end
    read_check(reg_addr(0, `REG_ADDR_LOW), 'h00);

    test_name = "replay_count";
    issue_cmd(0, replay_pkg::CMD_CLEAR);
    issue_cmd(0, replay_pkg::CMD_ENABLE);
    send_packet(0, 3);
    send_packet(0, 5);
    check_status(0, 0, 8);
    set_count(0, 3);
    start_replay(0);
    wait_drained();
    check_status(0, 0, 8);

    test_name = "dual_queue";
    issue_cmd(0, replay_pkg::CMD_CLEAR);
    issue_cmd(1, replay_pkg::CMD_CLEAR);
    issue_cmd(1, replay_pkg::CMD_ENABLE);
    send_packet(0, 4);
    send_packet(1, 5);
    send_packet(0, 6);
    send_packet(1, 3);
    check_status(0, 0, 10);
    check_status(1, 0, 8);
    set_count(0, 2);
    set_count(1, 3);
    rand_ready = 1'b1;
    start_replay(0);
    start_replay(1);
    wait_drained();
    rand_ready = 1'b0;
    check_status(0, 0, 10);
    check_status(1, 0, 8);

    test_name = "disabled_queue";
    issue_cmd(1, replay_pkg::CMD_DISABLE);
    issue_cmd(1, replay_pkg::CMD_CLEAR);
    send_packet(1, 4);
    check_status(1, 0, 0);
    start_replay(1);
    check_status(1, 0, 0);
    repeat (30) @(posedge axi_aclk);
    issue_cmd(1, replay_pkg::CMD_CLEAR);
    issue_cmd(1, replay_pkg::CMD_ENABLE);
    send_packet(1, 4);
    check_status(1, 0, 4);
    set_count(1, 1);
    start_replay(1);
    wait_drained();
    check_status(1, 0, 4);

    test_name = "region_stop";
    set_region(0, 'h80, 'h87);
    issue_cmd(0, replay_pkg::CMD_CLEAR);
    send_packet(0, 12);
    check_status(0, 0, 8);
    set_count(0, 200);
    start_replay(0);
    base = beats_seen[0];
    while (beats_seen[0] < base + 20) @(posedge axi_aclk);
    check_status(0, 1, 8);
    issue_cmd(0, replay_pkg::CMD_STOP);
    check_status(0, 0, 8);
    stop_mark = beats_seen[0];
    repeat (20) @(posedge axi_aclk);
    assert (beats_seen[0] - stop_mark <= `REPLAY_OUT_DEPTH)
      else fail_with("Output 0 kept streaming after the stop command");
    stop_mark = beats_seen[0];
    repeat (40) @(posedge axi_aclk);
    assert (beats_seen[0] == stop_mark)
      else fail_with("Output 0 sent beats long after the stop command");
    @(posedge axi_aclk);
    exp0.delete();

    if (exp0.size() == 0 && exp1.size() == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("Expected output beats were still outstanding at the end of the run");
      $display("Regression failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hw
hw/replay_pkg.sv
hw/replay_regs.sv
hw/capture_writer.sv
hw/packet_mem.sv
hw/replay_reader.sv
hw/replay_out.sv
hw/pcap_replay_top.sv
verif/replay_tb.sv
